// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_gate_array
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/cycle_sequencer.sv
`timescale 1ns/10ps

module cycle_sequencer (
	input  logic                       CLK_16M_N,
	input  logic                       rst_n,
	output logic [ga_pkg::PHASE_W-1:0] phase,
	output logic                       phi_n,
	output logic                       cclk
);

	// one phase per 16 MHz clock, so a full turn is 1 us
	always_ff @(posedge CLK_16M_N or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;	// wraps 15 -> 0
		end
	end

	// clock outputs decoded from the phase, one clock behind it
	always_ff @(posedge CLK_16M_N or negedge rst_n) begin
		if (!rst_n) begin
			phi_n <= 1'b0;
			cclk <= 1'b0;
		end else begin
			phi_n <= phase[1];	// 4 MHz, high in 2,3,6,7,...
			cclk <= phase[3];	// 1 MHz, high in 8..15
		end
	end

endmodule

// File: rtl/ga_pkg.sv
package ga_pkg;

	// sequencer
	localparam int PHASE_W = 4;	// 16 phases per microsecond

	localparam logic [PHASE_W-1:0] PH_VID_A = 4'd3;	// first video byte of the cycle
	localparam logic [PHASE_W-1:0] PH_VID_B = 4'd11;	// second video byte
	localparam logic [PHASE_W-1:0] PH_IO_WR = 4'd15;	// cpu i/o write strobe

	// colours and pens
	localparam int COLOUR_W = 5;	// hardware colour code
	localparam int PEN_W = 5;	// room for 32 pens
	localparam int PIX_W = 4;	// pen index out of the shifter

	localparam int PEN_BORDER_BIT = 4;	// pen select bit that picks the border
	localparam logic BORDER_PEN = 1'b1;	// value of that bit for the border

	typedef logic [COLOUR_W-1:0] colour_t;	// one palette entry

	// register group in d[7:6]
	typedef enum logic [1:0] {
		CMD_PEN_SEL = 2'b00,	// select pen or border
		CMD_INK = 2'b01,	// ink for selected pen
		CMD_CTRL = 2'b10,	// mode and rom enables
		CMD_UNUSED = 2'b11	// not decoded here
	} ga_cmd_e;

	// screen mode in the control register
	typedef enum logic [1:0] {
		MODE_0 = 2'b00,	// 160 px, 16 inks
		MODE_1 = 2'b01,	// 320 px, 4 inks
		MODE_2 = 2'b10,	// 640 px, 2 inks
		MODE_3 = 2'b11	// decoded as mode 0
	} screen_mode_e;

endpackage

// File: rtl/gate_array.sv
`timescale 1ns/10ps

module gate_array #(
	parameter int NUM_PENS = 16
) (
	input  logic            CLK_16M_N,
	input  logic            rst_n,
	input  logic            iorq_n,
	input  logic            m1_n,
	input  logic            mreq_n,
	input  logic            rd_n,
	input  logic            a15,
	input  logic            a14,
	input  logic [7:0]      d,
	input  logic            dispen,
	output logic            phi_n,
	output logic            cclk,
	output logic            romen_n,
	output logic            ramrd_n,
	output ga_pkg::colour_t colour
);
	import ga_pkg::*;

	logic [PHASE_W-1:0] phase;	// sequencer phase
	colour_t [NUM_PENS-1:0] palette;	// ink registers
	colour_t border;
	screen_mode_e mode;	// control register mode

	pixel_bus_if pix_bus ();	// shifter to palette

	cycle_sequencer i_cycle_sequencer (
		.CLK_16M_N (CLK_16M_N),
		.rst_n     (rst_n),
		.phase     (phase),
		.phi_n     (phi_n),
		.cclk      (cclk)
	);

	io_registers #(
		.NUM_PENS (NUM_PENS)
	) i_io_registers (
		.CLK_16M_N (CLK_16M_N),
		.rst_n     (rst_n),
		.phase     (phase),
		.iorq_n    (iorq_n),
		.m1_n      (m1_n),
		.mreq_n    (mreq_n),
		.rd_n      (rd_n),
		.a15       (a15),
		.a14       (a14),
		.d         (d),
		.palette   (palette),
		.border    (border),
		.mode      (mode),
		.romen_n   (romen_n),
		.ramrd_n   (ramrd_n)
	);

	pixel_shifter i_pixel_shifter (
		.CLK_16M_N (CLK_16M_N),
		.rst_n     (rst_n),
		.phase     (phase),
		.d         (d),
		.dispen    (dispen),
		.mode      (mode),
		.pix_bus   (pix_bus.shifter)
	);

	palette_lookup #(
		.NUM_PENS (NUM_PENS)
	) i_palette_lookup (
		.CLK_16M_N (CLK_16M_N),
		.rst_n     (rst_n),
		.pix_bus   (pix_bus.palette),
		.palette   (palette),
		.border    (border),
		.colour    (colour)
	);

endmodule

// File: rtl/io_registers.sv
`timescale 1ns/10ps

module io_registers #(
	parameter int NUM_PENS = 16
) (
	input  logic                                CLK_16M_N,
	input  logic                                rst_n,
	input  logic [ga_pkg::PHASE_W-1:0]          phase,
	input  logic                                iorq_n,
	input  logic                                m1_n,
	input  logic                                mreq_n,
	input  logic                                rd_n,
	input  logic                                a15,
	input  logic                                a14,
	input  logic [7:0]                          d,
	output ga_pkg::colour_t [NUM_PENS-1:0]      palette,
	output ga_pkg::colour_t                     border,
	output ga_pkg::screen_mode_e                mode,
	output logic                                romen_n,
	output logic                                ramrd_n
);
	import ga_pkg::*;

	logic [PEN_W-1:0] pen;	// pen select register
	logic lrom_dis;	// lower rom disable
	logic hrom_dis;	// upper rom disable
	logic io_wr;	// gate array write this clock
	ga_cmd_e cmd;	// register group
	logic rom_rd;	// address falls in an enabled rom
	logic mem_rd;	// cpu memory read cycle

	// port 7Fxx, only in the write slot of the sequence
	assign io_wr = (phase == PH_IO_WR) && !iorq_n && m1_n && !a15 && a14;
	assign cmd = ga_cmd_e'(d[7:6]);

	always_ff @(posedge CLK_16M_N or negedge rst_n) begin
		if (!rst_n) begin
			pen <= '0;
			border <= '0;
			palette <= '0;
			mode <= MODE_0;
			lrom_dis <= 1'b0;	// both roms mapped in
			hrom_dis <= 1'b0;
		end else if (io_wr) begin
			case (cmd)
				CMD_PEN_SEL: begin
					pen <= d[PEN_W-1:0];
				end
				CMD_INK: begin
					if (pen[PEN_BORDER_BIT] == BORDER_PEN) begin
						border <= d[COLOUR_W-1:0];	// pen 16 and up is the border
					end else begin
						for (int i = 0; i < NUM_PENS; i++) begin
							if (pen == PEN_W'(i)) begin
								palette[i] <= d[COLOUR_W-1:0];
							end
						end
					end
				end
				CMD_CTRL: begin
					mode <= screen_mode_e'(d[1:0]);	// used from next byte fetch
					lrom_dis <= d[2];
					hrom_dis <= d[3];
				end
				default: begin
					// interrupt control lives elsewhere
				end
			endcase
		end
	end

	// rom/ram mapping over cpu reads
	assign rom_rd = (!lrom_dis && !a15 && !a14) || (!hrom_dis && a15 && a14);
	assign mem_rd = !mreq_n && !rd_n;

	assign romen_n = !(rom_rd && mem_rd);	// rom chip select
	assign ramrd_n = !(!rom_rd && mem_rd);	// ram read enable

endmodule

// File: rtl/palette_lookup.sv
`timescale 1ns/10ps

module palette_lookup #(
	parameter int NUM_PENS = 16
) (
	input  logic                           CLK_16M_N,
	input  logic                           rst_n,
	pixel_bus_if.palette                   pix_bus,
	input  ga_pkg::colour_t [NUM_PENS-1:0] palette,
	input  ga_pkg::colour_t                border,
	output ga_pkg::colour_t                colour
);
	import ga_pkg::*;

	colour_t ink;	// ink of current pen
	colour_t next_colour;

	assign ink = palette[pix_bus.pix];

	// keep wins so a wide pixel stays one colour
	always_comb begin
		if (pix_bus.hold) begin
			next_colour = colour;
		end else if (pix_bus.border_sel) begin
			next_colour = border;
		end else if (pix_bus.pix_valid) begin
			next_colour = ink;
		end else begin
			next_colour = '0;	// nothing fetched yet
		end
	end

	always_ff @(posedge CLK_16M_N or negedge rst_n) begin
		if (!rst_n) begin
			colour <= '0;
		end else begin
			colour <= next_colour;	// one clock behind the pixel
		end
	end

endmodule

// File: rtl/pixel_bus_if.sv
`timescale 1ns/10ps

interface pixel_bus_if;
	import ga_pkg::*;

	logic [PIX_W-1:0] pix;	// pen index of current pixel
	logic pix_valid;	// inside display area
	logic border_sel;	// outside display area
	logic hold;	// keep last colour

	modport shifter (
		output pix,
		output pix_valid,
		output border_sel,
		output hold
	);

	modport palette (
		input pix,
		input pix_valid,
		input border_sel,
		input hold
	);

endinterface

// File: rtl/pixel_shifter.sv
`timescale 1ns/10ps

module pixel_shifter (
	input  logic                       CLK_16M_N,
	input  logic                       rst_n,
	input  logic [ga_pkg::PHASE_W-1:0] phase,
	input  logic [7:0]                 d,
	input  logic                       dispen,
	input  ga_pkg::screen_mode_e       mode,
	pixel_bus_if.shifter               pix_bus
);
	import ga_pkg::*;

	logic fetch;	// video byte on d
	logic load;	// latch holds a fresh byte
	logic [7:0] vid_byte;	// fetched byte
	logic vid_en;	// dispen at fetch
	screen_mode_e vid_mode;	// mode at fetch
	logic [7:0] sr;	// pixel shift register
	logic sr_full;	// a byte has been loaded since reset
	logic sr_en;	// display enable of byte in sr
	screen_mode_e sr_mode;	// mode of byte in sr
	logic [1:0] div_cnt;	// clocks since load
	logic mode_2;
	logic mode_1;
	logic step;	// shift at this edge

	assign fetch = (phase == PH_VID_A) || (phase == PH_VID_B);

	// fetch stage and shift stage, control part
	always_ff @(posedge CLK_16M_N or negedge rst_n) begin
		if (!rst_n) begin
			load <= 1'b0;
			vid_en <= 1'b0;
			vid_mode <= MODE_0;
			sr_full <= 1'b0;
			sr_en <= 1'b0;
			sr_mode <= MODE_0;
			div_cnt <= '0;
		end else begin
			load <= fetch;
			if (fetch) begin
				vid_en <= dispen;
				vid_mode <= mode;	// mode follows the byte down the pipe
			end
			if (load) begin
				sr_full <= 1'b1;
				sr_en <= vid_en;
				sr_mode <= vid_mode;
				div_cnt <= '0;	// restart pixel divider
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// pixel data
	always_ff @(posedge CLK_16M_N) begin
		if (fetch) begin
			vid_byte <= d;
		end
		if (load) begin
			sr <= vid_byte;
		end else if (step) begin
			sr <= {sr[6:0], 1'b0};
		end
	end

	assign mode_2 = (sr_mode == MODE_2);
	assign mode_1 = (sr_mode == MODE_1);
	assign step = mode_2 || (mode_1 && div_cnt[0]) || (&div_cnt);	// 1, 2 or 4 clocks

	// pen index, bit order as the crtc ram layout
	always_comb begin
		case (sr_mode)
			MODE_2: pix_bus.pix = {3'b000, sr[7]};
			MODE_1: pix_bus.pix = {2'b00, sr[7], sr[3]};
			default: pix_bus.pix = {sr[7], sr[3], sr[5], sr[1]};	// modes 0 and 3
		endcase
	end

	assign pix_bus.pix_valid = sr_full && sr_en;
	assign pix_bus.border_sel = sr_full && !sr_en;
	assign pix_bus.hold = !mode_2 && (mode_1 ? div_cnt[0] : |div_cnt);	// mid pixel

endmodule

// File: sim.f
rtl/ga_pkg.sv
rtl/pixel_bus_if.sv
rtl/cycle_sequencer.sv
rtl/io_registers.sv
rtl/pixel_shifter.sv
rtl/palette_lookup.sv
rtl/gate_array.sv
tests/clk_gen.sv
tests/gate_array_asserts.sv
tests/tb_gate_array.sv

// File: tests/clk_gen.sv
`timescale 1ns/10ps

module clk_gen (
	output logic CLK_16M_N,
	output logic rst_n
);

	initial begin
		CLK_16M_N = 1'b0;
		forever #2 CLK_16M_N = ~CLK_16M_N;	// 4 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge CLK_16M_N);
		@(negedge CLK_16M_N);	// release away from the active edge
		rst_n = 1'b1;
	end

endmodule

// File: tests/gate_array_asserts.sv
`timescale 1ns/10ps

module gate_array_asserts (
	input logic       CLK_16M_N,
	input logic       rst_n,
	input logic       mreq_n,
	input logic       rd_n,
	input logic       phi_n,
	input logic       cclk,
	input logic       romen_n,
	input logic       ramrd_n,
	input logic [4:0] colour
);

	logic [3:0] cnt;	// phase count since reset release
	logic [3:0] last_cnt;	// phase of the previous clock
	logic seen;	// at least one clock since release
	int fail_count = 0;	// failed assertions, read by the testbench

	always_ff @(posedge CLK_16M_N or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			last_cnt <= '0;
			seen <= 1'b0;
		end else begin
			cnt <= cnt + 4'd1;
			last_cnt <= cnt;
			seen <= 1'b1;
		end
	end

	// outputs quiet in reset, once a reset edge has been seen
	in_reset: assert property (@(posedge CLK_16M_N)
		!rst_n && $past(!rst_n) |-> (colour == 5'd0) && !phi_n && !cclk)
		else begin
			$error("outputs not cleared during reset");
			fail_count++;
		end

	// and on the first clock after it
	after_reset: assert property (@(posedge CLK_16M_N)
		$rose(rst_n) |-> (colour == 5'd0) && !phi_n && !cclk)
		else begin
			$error("outputs not cleared right after reset");
			fail_count++;
		end

	phi_rule: assert property (@(posedge CLK_16M_N) disable iff (!rst_n)
		seen |-> phi_n == last_cnt[1])	// registered, one clock behind
		else begin
			$error("phi_n does not follow the phase");
			fail_count++;
		end

	cclk_rule: assert property (@(posedge CLK_16M_N) disable iff (!rst_n)
		seen |-> cclk == last_cnt[3])
		else begin
			$error("cclk does not follow the phase");
			fail_count++;
		end

	// no select without a memory read, exactly one select during one
	read_select: assert property (@(posedge CLK_16M_N) disable iff (!rst_n)
		(mreq_n || rd_n) ? (romen_n && ramrd_n) : (romen_n != ramrd_n))
		else begin
			$error("romen_n and ramrd_n do not match the read strobes");
			fail_count++;
		end

endmodule

bind gate_array gate_array_asserts i_gate_array_asserts (.*);

// File: tests/tb_gate_array.sv
`timescale 1ns/10ps

module tb_gate_array;

	localparam int SETUP_WRITES = 35;	// mode, 16 pens with inks, border pen and ink
	localparam int VIDEO_CLKS = 64 + 3 * 128;	// border, mode 2, mode 1, mode 0
	localparam int SWEEP_CLKS = 4 * (16 + 20 + 16);	// write slot, settle, combinations
	localparam int TEST_CLKS = SETUP_WRITES * 16 + 20 + VIDEO_CLKS + SWEEP_CLKS;
	localparam int BYTE_TIMES = (TEST_CLKS + 15) / 16;
	localparam int TIMEOUT_NS = BYTE_TIMES * 16 * 4 + 1000;	// margin for reset

	logic CLK_16M_N, rst_n;
	logic iorq_n, m1_n, mreq_n, rd_n, a15, a14, dispen;
	logic [7:0] d;
	logic phi_n, cclk, romen_n, ramrd_n;
	logic [4:0] colour;

	int errors = 0;
	logic [31:0] seed = 32'd43098;
	logic [3:0] ph = '0;	// dut phase during this clock
	logic [7:0] io_q[$];	// pending gate array writes
	int hold_off = 0;	// clocks left with the colour check off

	// register model
	logic [4:0] pal[16];
	logic [4:0] brd = '0;
	logic [4:0] pen = '0;
	logic [1:0] mdl_mode = 2'd0;
	logic lrom_dis = 1'b0;
	logic hrom_dis = 1'b0;

	// pixel model
	logic vid_dispen = 1'b0;
	logic [7:0] pend_b, cur_b;
	logic pend_en, cur_en;
	logic [1:0] pend_m, cur_m;
	logic have = 1'b0;	// a byte is on screen
	int j = 0;	// clock within the byte on screen

	clk_gen i_clk_gen (.CLK_16M_N(CLK_16M_N), .rst_n(rst_n));

	gate_array #(.NUM_PENS(16)) i_gate_array (.*);

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired, the run did not finish in time");
		$display("** FAIL **");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic logic [4:0] expected_colour();
		logic [7:0] b;
		logic [3:0] idx;
		int k;
		k = (cur_m == 2'd2) ? j : (cur_m == 2'd1) ? j / 2 : j / 4;	// pixel number
		b = cur_b << k;
		case (cur_m)
			2'd2: idx = {3'b000, b[7]};
			2'd1: idx = {2'b00, b[7], b[3]};
			default: idx = {b[7], b[3], b[5], b[1]};
		endcase
		return cur_en ? pal[idx] : brd;
	endfunction

	task automatic apply_write(input logic [7:0] v);
		case (v[7:6])
			2'b00: pen = v[4:0];
			2'b01: begin
				if (pen[4]) brd = v[4:0];
				else pal[pen[3:0]] = v[4:0];
				hold_off = 20;	// ink changes mid byte
			end
			2'b10: begin
				mdl_mode = v[1:0];
				lrom_dis = v[2];
				hrom_dis = v[3];
			end
			default: ;
		endcase
	endtask

	// one clock: check colour, then drive the next inputs
	task automatic step();
		logic [31:0] r;
		@(posedge CLK_16M_N);
		ph = ph + 4'd1;
		#1;
		if (ph == 4'd6 || ph == 4'd14) begin	// byte fetched 3 phases ago
			cur_b = pend_b;
			cur_en = pend_en;
			cur_m = pend_m;
			have = 1'b1;
			j = 0;
		end else begin
			j++;
		end
		if (have && hold_off == 0) begin
			assert (colour === expected_colour()) else begin
				errors++;
				$display("Fail %0t: colour %h, expected %h", $time, colour,
					expected_colour());
			end
		end
		if (hold_off > 0) hold_off--;
		iorq_n = 1'b1;
		d = '0;
		if (ph == 4'd3 || ph == 4'd11) begin	// video slot
			r = lcg_next();
			d = r[23:16];
			dispen = vid_dispen;
			pend_b = d;
			pend_en = vid_dispen;
			pend_m = mdl_mode;
		end else if (ph == 4'd15 && io_q.size() > 0) begin
			d = io_q.pop_front();
			iorq_n = 1'b0;
			a15 = 1'b0;	// port 7Fxx
			a14 = 1'b1;
			apply_write(d);
		end
	endtask

	task automatic run(input int n);
		repeat (n) step();
	endtask

	task automatic drain_writes();
		while (io_q.size() > 0) step();
		run(20);
	endtask

	// all a15/a14/mreq_n/rd_n combinations against the memory map
	task automatic rom_sweep(input logic [7:0] ctrl);
		logic [15:0] addr;
		logic rd;
		logic rom;
		logic exp_romen_n;
		logic exp_ramrd_n;
		io_q.push_back(ctrl);
		drain_writes();
		for (int i = 0; i < 16; i++) begin
			step();
			{a15, a14, mreq_n, rd_n} = 4'(i);
			#1;
			addr = {a15, a14, 14'h0000};	// base of the 16k bank
			rd = !mreq_n && !rd_n;
			rom = (addr <= 16'h3fff && !lrom_dis) || (addr >= 16'hc000 && !hrom_dis);
			exp_romen_n = !(rd && rom);
			exp_ramrd_n = !(rd && !rom);
			assert (romen_n === exp_romen_n && ramrd_n === exp_ramrd_n) else begin
				errors++;
				$display("Fail %0t: romen_n %b ramrd_n %b for a15 a14 mreq_n rd_n %b",
					$time, romen_n, ramrd_n, 4'(i));
			end
		end
		mreq_n = 1'b1;
		rd_n = 1'b1;
	endtask

	initial begin
		logic [31:0] r;
		int asrt_errors;
		iorq_n = 1'b1;
		m1_n = 1'b1;
		mreq_n = 1'b1;
		rd_n = 1'b1;
		a15 = 1'b0;
		a14 = 1'b0;
		d = '0;
		dispen = 1'b0;
		for (int i = 0; i < 16; i++) pal[i] = '0;
		wait (rst_n === 1'b1);
		io_q.push_back(8'h82);	// mode 2, both roms on
		for (int p = 0; p < 16; p++) begin
			r = lcg_next();
			io_q.push_back(8'(p));
			io_q.push_back({3'b010, r[20:16]});
		end
		r = lcg_next();
		io_q.push_back(8'h10);	// border pen
		io_q.push_back({3'b010, r[20:16]});
		drain_writes();
		run(64);	// border only
		vid_dispen = 1'b1;
		run(128);
		io_q.push_back(8'h81);	// mode 1 from next fetch
		run(128);
		io_q.push_back(8'h80);	// mode 0
		run(128);
		rom_sweep(8'h80);
		rom_sweep(8'h84);	// lower rom off
		rom_sweep(8'h88);	// upper rom off
		rom_sweep(8'h8c);
		asrt_errors = i_gate_array.i_gate_array_asserts.fail_count;
		$display("errors: %0d checks, %0d assertions", errors, asrt_errors);
		if (errors == 0 && asrt_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
